//--- source/ex_alu_pkg.sv
// Operator set and field widths of the replicated ALU; the voter and the fault_flip field assume exactly 4 replicas
`default_nettype none

package ex_alu_pkg;

  // Operand and result width
  localparam int unsigned DATA_WIDTH = 32;
  // Destination register address width
  localparam int unsigned WADDR_WIDTH = 6;
  // Number of ALU copies, sizes spare_sel and fault_flip
  localparam int unsigned NUM_REPLICAS = 4;
  localparam int unsigned SEL_WIDTH = $clog2(NUM_REPLICAS);

  // Operator encoding
  // Shifts use the low 5 bits of operand b
  // SLT is signed and returns 0 or 1
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLL = 3'd5,
    SRL = 3'd6,
    SLT = 3'd7
  } alu_op_e;

  // Request into the execute stage
  typedef struct packed {
    alu_op_e                 op;
    logic [DATA_WIDTH-1:0]   operand_a;
    logic [DATA_WIDTH-1:0]   operand_b;
    logic [WADDR_WIDTH-1:0]  waddr;
    // Replica that sits out of the vote
    logic [SEL_WIDTH-1:0]    spare_sel;
    // Bit k set makes replica k invert result bit k
    logic [NUM_REPLICAS-1:0] fault_flip;
  } ex_req_t;

  // Voted response
  typedef struct packed {
    logic [DATA_WIDTH-1:0]  result;
    logic [WADDR_WIDTH-1:0] waddr;
    logic                   corrected;
    logic                   detected;
  } ex_rsp_t;

endpackage

`default_nettype wire

//--- source/ex_ft_pkg.sv
// Fault bookkeeping types; counts saturate at the top of CNT_WIDTH, so thresholds above 511 never fire
`default_nettype none

package ex_ft_pkg;

  // Width of each per-replica mismatch counter
  localparam int unsigned CNT_WIDTH = 9;

  //////////////////////////////////////////////////
  // Fault status reported to the outside
  //////////////////////////////////////////////////

  // Permanent mask in the upper bits
  // Count of replica k at count[k]
  typedef struct packed {
    logic [ex_alu_pkg::NUM_REPLICAS-1:0]                permanent;
    logic [ex_alu_pkg::NUM_REPLICAS-1:0][CNT_WIDTH-1:0] count;
  } fault_status_t;

endpackage

`default_nettype wire

//--- source/ex_pipe_stage.sv
// Single-entry valid/ready register; ready_o depends combinationally on ready_i, so chained stages form a ready path
`timescale 1ns/10ps
`default_nettype none

module ex_pipe_stage #(
  parameter type payload_t = logic
) (
  input  wire      clk,
  input  wire      rst_n,
  // Upstream side
  input  wire      valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  wire      ready_i,
  output payload_t data_o,
  // High in each cycle a new item enters
  output logic     load_o
);

  logic     valid_q;
  payload_t data_q;

  // Free when empty or when the held item leaves this cycle
  assign ready_o = ~valid_q | ready_i;
  assign load_o  = valid_i & ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload held under stall
  always_ff @(posedge clk) begin
    if (load_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

//--- source/ex_alu_core.sv
// One combinational ALU replica; REPLICA_IDX must be below the replica count and selects the injected bit
`timescale 1ns/10ps
`default_nettype none

module ex_alu_core #(
  parameter int unsigned REPLICA_IDX = 0
) (
  input  ex_alu_pkg::ex_req_t                  req_i,
  output logic [ex_alu_pkg::DATA_WIDTH-1:0]    result_o
);

  logic [ex_alu_pkg::DATA_WIDTH-1:0] alu_res;
  logic [ex_alu_pkg::DATA_WIDTH-1:0] flip_mask;
  logic [4:0]                        shamt;
  logic                              less_than;

  // Shift amount from the low bits of b
  assign shamt = req_i.operand_b[4:0];

  // Signed compare for SLT
  assign less_than = $signed(req_i.operand_a) < $signed(req_i.operand_b);

  //////////////////////////////////////////////////
  // Operator decode
  //////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      ex_alu_pkg::ADD: alu_res = req_i.operand_a + req_i.operand_b;
      ex_alu_pkg::SUB: alu_res = req_i.operand_a - req_i.operand_b;
      ex_alu_pkg::AND: alu_res = req_i.operand_a & req_i.operand_b;
      ex_alu_pkg::OR:  alu_res = req_i.operand_a | req_i.operand_b;
      ex_alu_pkg::XOR: alu_res = req_i.operand_a ^ req_i.operand_b;
      ex_alu_pkg::SLL: alu_res = req_i.operand_a << shamt;
      ex_alu_pkg::SRL: alu_res = req_i.operand_a >> shamt;
      ex_alu_pkg::SLT: alu_res = {{(ex_alu_pkg::DATA_WIDTH-1){1'b0}}, less_than};
      default:         alu_res = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Fault injection
  //////////////////////////////////////////////////

  // Only this replica's own bit of fault_flip matters
  always_comb begin
    flip_mask              = '0;
    flip_mask[REPLICA_IDX] = req_i.fault_flip[REPLICA_IDX];
  end

  // Inverts result bit REPLICA_IDX when injected
  assign result_o = alu_res ^ flip_mask;

endmodule

`default_nettype wire

//--- source/ex_majority_voter.sv
// Three-of-four voter built for exactly 4 replicas; on a three-way split it forwards the lowest selected replica
`timescale 1ns/10ps
`default_nettype none

module ex_majority_voter (
  input  wire  [ex_alu_pkg::NUM_REPLICAS-1:0][ex_alu_pkg::DATA_WIDTH-1:0] result_i,
  input  wire  [ex_alu_pkg::SEL_WIDTH-1:0]    spare_sel_i,
  input  wire  [ex_alu_pkg::WADDR_WIDTH-1:0]  waddr_i,
  output ex_alu_pkg::ex_rsp_t                 rsp_o,
  output logic [ex_alu_pkg::NUM_REPLICAS-1:0] mismatch_o
);

  // Indices of the three voters in ascending order
  logic [2:0][ex_alu_pkg::SEL_WIDTH-1:0]  vote_idx;
  logic [2:0][ex_alu_pkg::DATA_WIDTH-1:0] vote_val;
  logic [ex_alu_pkg::DATA_WIDTH-1:0]      chosen;
  logic                                   eq01;
  logic                                   eq02;
  logic                                   eq12;

  // Voter k is replica k, shifted past the spare
  always_comb begin
    for (int k = 0; k < 3; k++) begin
      vote_idx[k] = ex_alu_pkg::SEL_WIDTH'(k)
                  + ex_alu_pkg::SEL_WIDTH'(spare_sel_i <= ex_alu_pkg::SEL_WIDTH'(k));
      vote_val[k] = result_i[vote_idx[k]];
    end
  end

  assign eq01 = vote_val[0] == vote_val[1];
  assign eq02 = vote_val[0] == vote_val[2];
  assign eq12 = vote_val[1] == vote_val[2];

  //////////////////////////////////////////////////
  // Vote and flags
  //////////////////////////////////////////////////

  always_comb begin
    rsp_o.waddr     = waddr_i;
    rsp_o.corrected = 1'b0;
    rsp_o.detected  = 1'b0;
    chosen          = vote_val[0];
    if (eq01 && eq02) begin
      // Unanimous
      chosen = vote_val[0];
    end else if (eq01 || eq02) begin
      // Voter 0 sides with one other
      chosen          = vote_val[0];
      rsp_o.corrected = 1'b1;
    end else if (eq12) begin
      // Voter 0 is the odd one out
      chosen          = vote_val[1];
      rsp_o.corrected = 1'b1;
    end else begin
      // No majority, lowest selected replica passes through
      rsp_o.detected = 1'b1;
    end
    rsp_o.result = chosen;
  end

  // Voting replicas that disagree with the outcome
  // The spare is never blamed
  always_comb begin
    for (int i = 0; i < ex_alu_pkg::NUM_REPLICAS; i++) begin
      mismatch_o[i] = (ex_alu_pkg::SEL_WIDTH'(i) != spare_sel_i) && (result_i[i] != chosen);
    end
  end

endmodule

`default_nettype wire

//--- source/ex_fault_monitor.sv
// Mismatch counters saturate at 511; FAULT_THRESHOLD must lie in 1 to 511 for the permanent flag to be reachable
`timescale 1ns/10ps
`default_nettype none

module ex_fault_monitor #(
  parameter int unsigned FAULT_THRESHOLD = 8
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  // Stage two load strobe
  input  wire                                  update_i,
  input  wire  [ex_alu_pkg::NUM_REPLICAS-1:0]  mismatch_i,
  output ex_ft_pkg::fault_status_t             status_o,
  output logic [ex_alu_pkg::NUM_REPLICAS-1:0]  pulse_o
);

  localparam logic [ex_ft_pkg::CNT_WIDTH-1:0] CNT_MAX = '1;
  localparam logic [ex_ft_pkg::CNT_WIDTH-1:0] THRESHOLD = ex_ft_pkg::CNT_WIDTH'(FAULT_THRESHOLD);

  logic [ex_alu_pkg::NUM_REPLICAS-1:0][ex_ft_pkg::CNT_WIDTH-1:0] cnt_q;

  //////////////////////////////////////////////////
  // Saturating counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (update_i) begin
      for (int i = 0; i < ex_alu_pkg::NUM_REPLICAS; i++) begin
        if (mismatch_i[i] && (cnt_q[i] != CNT_MAX)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // Permanent while at or above threshold
  always_comb begin
    status_o.count = cnt_q;
    for (int i = 0; i < ex_alu_pkg::NUM_REPLICAS; i++) begin
      status_o.permanent[i] = cnt_q[i] >= THRESHOLD;
    end
  end

  // One-cycle pulse per counted mismatch
  assign pulse_o = {ex_alu_pkg::NUM_REPLICAS{update_i}} & mismatch_i;

endmodule

`default_nettype wire

//--- source/ex_ft_stage.sv
// Fault-tolerant execute core with two-cycle latency and two items in flight; spare_sel and fault_flip come with each request
`timescale 1ns/10ps
`default_nettype none

module ex_ft_stage #(
  parameter int unsigned FAULT_THRESHOLD = 8
) (
  input  wire                                 clk,
  input  wire                                 rst_n,
  // Request channel
  input  wire                                 req_valid_i,
  output logic                                req_ready_o,
  input  ex_alu_pkg::ex_req_t                 req_i,
  // Response channel
  output logic                                rsp_valid_o,
  input  wire                                 rsp_ready_i,
  output ex_alu_pkg::ex_rsp_t                 rsp_o,
  // Fault status
  output ex_ft_pkg::fault_status_t            fault_status_o,
  output logic [ex_alu_pkg::NUM_REPLICAS-1:0] fault_pulse_o
);

  ex_alu_pkg::ex_req_t                                            req_q;
  logic                                                           req_valid_q;
  logic                                                           rsp_stage_ready;
  logic                                                           rsp_load;
  logic [ex_alu_pkg::NUM_REPLICAS-1:0][ex_alu_pkg::DATA_WIDTH-1:0] replica_result;
  ex_alu_pkg::ex_rsp_t                                            vote_rsp;
  logic [ex_alu_pkg::NUM_REPLICAS-1:0]                            mismatch;

  //////////////////////////////////////////////////
  // Request register
  //////////////////////////////////////////////////

  // Its load strobe is not needed
  ex_pipe_stage #(
    .payload_t (ex_alu_pkg::ex_req_t)
  ) req_stage_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_i  (req_i),
    .valid_o (req_valid_q),
    .ready_i (rsp_stage_ready),
    .data_o  (req_q),
    .load_o  ()
  );

  // Four replicas see the same registered request
  for (genvar i = 0; i < ex_alu_pkg::NUM_REPLICAS; i++) begin : g_replica
    ex_alu_core #(
      .REPLICA_IDX (i)
    ) alu_core_i (
      .req_i    (req_q),
      .result_o (replica_result[i])
    );
  end

  ex_majority_voter voter_i (
    .result_i    (replica_result),
    .spare_sel_i (req_q.spare_sel),
    .waddr_i     (req_q.waddr),
    .rsp_o       (vote_rsp),
    .mismatch_o  (mismatch)
  );

  //////////////////////////////////////////////////
  // Response register and fault tracking
  //////////////////////////////////////////////////

  ex_pipe_stage #(
    .payload_t (ex_alu_pkg::ex_rsp_t)
  ) rsp_stage_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (req_valid_q),
    .ready_o (rsp_stage_ready),
    .data_i  (vote_rsp),
    .valid_o (rsp_valid_o),
    .ready_i (rsp_ready_i),
    .data_o  (rsp_o),
    .load_o  (rsp_load)
  );

  // Counts each voted item once, as it enters stage two
  ex_fault_monitor #(
    .FAULT_THRESHOLD (FAULT_THRESHOLD)
  ) fault_monitor_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .update_i   (rsp_load),
    .mismatch_i (mismatch),
    .status_o   (fault_status_o),
    .pulse_o    (fault_pulse_o)
  );

endmodule

`default_nettype wire

//--- testbench/ex_ft_checker.sv
// Protocol assertions bound into ex_ft_stage; the failure counter is read by the testbench top module
`timescale 1ns/10ps
`default_nettype none

module ex_ft_checker (
  input wire                 clk,
  input wire                 rst_n,
  input wire                 rsp_valid_i,
  input wire                 rsp_ready_i,
  input ex_alu_pkg::ex_rsp_t rsp_i
);

  // Number of assertion failures so far
  int unsigned assert_fail_count = 0;

  // Stalled response keeps its payload
  assert property (@(posedge clk) disable iff (!rst_n)
                   (rsp_valid_i && !rsp_ready_i) |=> $stable(rsp_i))
    else begin
      assert_fail_count++;
      $error("rsp_o changed while the response was stalled");
    end

  // A response is either corrected or detected, not both
  assert property (@(posedge clk) disable iff (!rst_n)
                   rsp_valid_i |-> !(rsp_i.corrected && rsp_i.detected))
    else begin
      assert_fail_count++;
      $error("corrected and detected are both set");
    end

  // Pipeline comes out of reset empty
  assert property (@(posedge clk) $rose(rst_n) |-> !rsp_valid_i)
    else begin
      assert_fail_count++;
      $error("rsp_valid_o is high in the first cycle after reset");
    end

endmodule

bind ex_ft_stage ex_ft_checker checker_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .rsp_valid_i (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .rsp_i       (rsp_o)
);

`default_nettype wire

//--- testbench/ex_ft_scoreboard.sv
// Reference model for the execute core; assumes 4 replicas and counts that saturate at the top of CNT_WIDTH
`timescale 1ns/10ps
`default_nettype none

module ex_ft_scoreboard #(
  parameter int unsigned THRESHOLD = 8
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      req_valid_i,
  input  wire                      req_ready_i,
  input  ex_alu_pkg::ex_req_t      req_i,
  input  wire                      rsp_valid_i,
  input  wire                      rsp_ready_i,
  input  ex_alu_pkg::ex_rsp_t      rsp_i,
  input  ex_ft_pkg::fault_status_t fault_status_i,
  input  wire  [3:0]               fault_pulse_i,
  output int unsigned              check_count_o,
  output int unsigned              error_count_o,
  output int unsigned              rsp_count_o
);

  localparam int unsigned CNT_MAX = (1 << ex_ft_pkg::CNT_WIDTH) - 1;

  ex_alu_pkg::ex_rsp_t exp_q[$];
  logic [3:0]          mm_q[$];
  logic [3:0]          pulse_q[$];
  int unsigned         model_cnt[4];
  ex_alu_pkg::ex_rsp_t exp_rsp;
  logic [3:0]          exp_mm;
  logic [3:0]          exp_pulse;
  logic                s1_full = 1'b0;
  logic                s2_full = 1'b0;
  logic                load_two;
  int unsigned         checks = 0;
  int unsigned         errors = 0;
  int unsigned         responses = 0;

  assign check_count_o = checks;
  assign error_count_o = errors;
  assign rsp_count_o   = responses;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Operator table
  function automatic logic [31:0] alu_ref(input ex_alu_pkg::ex_req_t r);
    logic [31:0] a;
    logic [31:0] b;
    a = r.operand_a;
    b = r.operand_b;
    case (r.op)
      ex_alu_pkg::ADD: return a + b;
      ex_alu_pkg::SUB: return a - b;
      ex_alu_pkg::AND: return a & b;
      ex_alu_pkg::OR:  return a | b;
      ex_alu_pkg::XOR: return a ^ b;
      ex_alu_pkg::SLL: return a << b[4:0];
      ex_alu_pkg::SRL: return a >> b[4:0];
      default:         return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
  endfunction

  // Replica flips, then majority of the three voters
  function automatic void predict(input ex_alu_pkg::ex_req_t r,
                                  output ex_alu_pkg::ex_rsp_t rsp, output logic [3:0] mm);
    logic [3:0][31:0] res;
    int               voter[3];
    int               n;
    int               best;
    int               agree;
    int               same;
    n    = 0;
    best = -1;
    for (int k = 0; k < 4; k++) begin
      res[k] = alu_ref(r);
      if (r.fault_flip[k]) begin
        res[k][k] = ~res[k][k];
      end
      if (k != int'(r.spare_sel)) begin
        voter[n] = k;
        n = n + 1;
      end
    end
    // First voter that has company wins
    for (int i = 0; i < 3; i++) begin
      same = 0;
      for (int j = 0; j < 3; j++) begin
        if (res[voter[i]] == res[voter[j]]) same++;
      end
      if (same >= 2 && best < 0) begin
        best  = i;
        agree = same;
      end
    end
    rsp.waddr     = r.waddr;
    rsp.detected  = (best < 0);
    rsp.corrected = (best >= 0) && (agree == 2);
    rsp.result    = (best < 0) ? res[voter[0]] : res[voter[best]];
    for (int k = 0; k < 4; k++) begin
      mm[k] = (k != int'(r.spare_sel)) && (res[k] != rsp.result);
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_q.delete();
      mm_q.delete();
      pulse_q.delete();
      s1_full = 1'b0;
      s2_full = 1'b0;
      foreach (model_cnt[k]) model_cnt[k] = 0;
    end else begin
      // Stage occupancy model checked on every edge
      load_two  = s1_full && (!s2_full || rsp_ready_i);
      exp_pulse = 4'b0000;
      if (load_two) begin
        exp_pulse = pulse_q.pop_front();
      end
      check_value("rsp_valid_o", 32'(s2_full), 32'(rsp_valid_i));
      check_value("req_ready_o", 32'(!s1_full || !s2_full || rsp_ready_i), 32'(req_ready_i));
      check_value("fault_pulse_o", 32'(exp_pulse), 32'(fault_pulse_i));
      s2_full = load_two || (s2_full && !rsp_ready_i);
      s1_full = (req_valid_i && req_ready_i) || (s1_full && !load_two);
      if (rsp_valid_i && rsp_ready_i) begin
        responses++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("At %0t a response arrived with no request pending", $time);
        end else begin
          exp_rsp = exp_q.pop_front();
          exp_mm  = mm_q.pop_front();
          check_value("rsp_o.result", exp_rsp.result, rsp_i.result);
          check_value("rsp_o.waddr", 32'(exp_rsp.waddr), 32'(rsp_i.waddr));
          check_value("rsp_o.corrected", 32'(exp_rsp.corrected), 32'(rsp_i.corrected));
          check_value("rsp_o.detected", 32'(exp_rsp.detected), 32'(rsp_i.detected));
          // Counts include this item and nothing newer
          for (int k = 0; k < 4; k++) begin
            if (exp_mm[k] && model_cnt[k] < CNT_MAX) model_cnt[k]++;
            check_value($sformatf("fault_status_o.count[%0d]", k), model_cnt[k],
                        32'(fault_status_i.count[k]));
            check_value($sformatf("fault_status_o.permanent[%0d]", k),
                        32'(model_cnt[k] >= THRESHOLD), 32'(fault_status_i.permanent[k]));
          end
        end
      end
      if (req_valid_i && req_ready_i) begin
        predict(req_i, exp_rsp, exp_mm);
        exp_q.push_back(exp_rsp);
        mm_q.push_back(exp_mm);
        pulse_q.push_back(exp_mm);
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_ex_ft_stage.sv
// Testbench for ex_ft_stage with FAULT_THRESHOLD 8; stimulus from a fixed-seed LFSR, one request per cycle
`timescale 1ns/10ps
`default_nettype none

module tb_ex_ft_stage;

  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned THRESHOLD    = 8;
  localparam int unsigned RESET_CYCLES = 10;
  localparam logic [31:0] SEED         = 32'h7109_a8c3;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     req_valid_i;
  logic                     req_ready_o;
  ex_alu_pkg::ex_req_t      req_i;
  logic                     rsp_valid_o;
  logic                     rsp_ready_i;
  ex_alu_pkg::ex_rsp_t      rsp_o;
  ex_ft_pkg::fault_status_t fault_status_o;
  logic [3:0]               fault_pulse_o;
  logic [31:0]              lfsr_state;
  logic                     rand_ready;
  int unsigned              sent;
  int unsigned              check_count;
  int unsigned              error_count;
  int unsigned              rsp_count;

  always #(CLK_PERIOD / 2) clk = ~clk;

  ex_ft_stage #(
    .FAULT_THRESHOLD (THRESHOLD)
  ) ex_ft_stage_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_i          (req_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_o          (rsp_o),
    .fault_status_o (fault_status_o),
    .fault_pulse_o  (fault_pulse_o)
  );

  ex_ft_scoreboard #(
    .THRESHOLD (THRESHOLD)
  ) scoreboard_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_ready_i    (req_ready_o),
    .req_i          (req_i),
    .rsp_valid_i    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_i          (rsp_o),
    .fault_status_i (fault_status_o),
    .fault_pulse_i  (fault_pulse_o),
    .check_count_o  (check_count),
    .error_count_o  (error_count),
    .rsp_count_o    (rsp_count)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned width);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int unsigned i = 0; i < width; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value      = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic int unsigned test_ops(input int t);
    case (t)
      1:       return 200;
      2:       return 40;
      3:       return 20;
      4:       return 20;
      5:       return 200;
      default: return 520;
    endcase
  endfunction

  function automatic ex_alu_pkg::ex_req_t random_req(input logic [1:0] spare,
                                                     input logic [3:0] flip);
    ex_alu_pkg::ex_req_t r;
    r.op         = ex_alu_pkg::alu_op_e'(rand_bits(3));
    r.operand_a  = rand_bits(32);
    r.operand_b  = rand_bits(32);
    r.waddr      = rand_bits(6);
    r.spare_sel  = spare;
    r.fault_flip = flip;
    return r;
  endfunction

  // Response ready, random only in test 5
  task automatic step_ready();
    rsp_ready_i = rand_ready ? rand_bits(1) : 1'b1;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // Holds the request from a falling edge until a rising edge takes it
  task automatic issue(input ex_alu_pkg::ex_req_t r);
    logic accepted;
    req_valid_i = 1'b1;
    req_i       = r;
    accepted    = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = req_ready_o;
      @(negedge clk);
      step_ready();
    end
    req_valid_i = 1'b0;
    sent++;
  endtask

  task automatic drain();
    while (rsp_count < sent) begin
      @(negedge clk);
      step_ready();
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic run_test(input int t);
    int unsigned err_before;
    int unsigned n;
    logic [1:0]  spare;
    logic [1:0]  pick;
    logic [3:0]  flip;
    err_before = error_count;
    rand_ready = (t == 5);
    for (n = 0; n < test_ops(t); n++) begin
      spare = rand_bits(2);
      // A voting replica other than the spare
      pick  = rand_bits(2);
      if (pick == spare) pick = pick + 2'd1;
      case (t)
        1:       flip = 4'b0000;
        2:       flip = 4'b0001 << pick;
        3:       flip = 4'b0001 << spare;
        4:       flip = ~((4'b0001 << spare) | (4'b0001 << pick));
        5:       flip = rand_bits(4);
        default: begin
          // Replica 1 votes and fails every time
          spare = 2'd3;
          flip  = 4'b0010;
        end
      endcase
      issue(random_req(spare, flip));
    end
    drain();
    rand_ready  = 1'b0;
    rsp_ready_i = 1'b1;
    $display("Test %0d: %0d operations, %0d errors", t, test_ops(t), error_count - err_before);
  endtask

  initial begin
    int unsigned total_errors;
    lfsr_state  = SEED;
    rst_n       = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b1;
    rand_ready  = 1'b0;
    sent        = 0;
    apply_reset();
    for (int t = 1; t <= 6; t++) begin
      // Fresh counters so the threshold crossing is seen from zero
      if (t == 6) apply_reset();
      run_test(t);
    end
    total_errors = error_count + ex_ft_stage_i.checker_i.assert_fail_count;
    $display("6 tests, %0d requests, %0d checks, %0d errors", sent, check_count, total_errors);
    if (total_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog at 8 cycles per operation
  initial begin
    longint unsigned limit;
    limit = 0;
    for (int t = 1; t <= 6; t++) limit += test_ops(t);
    limit = limit * 8 * CLK_PERIOD;
    #(limit);
    $display("Watchdog expired before every request got its response");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
source/ex_alu_pkg.sv
source/ex_ft_pkg.sv
source/ex_pipe_stage.sv
source/ex_alu_core.sv
source/ex_majority_voter.sv
source/ex_fault_monitor.sv
source/ex_ft_stage.sv
testbench/ex_ft_checker.sv
testbench/ex_ft_scoreboard.sv
testbench/tb_ex_ft_stage.sv

//--- Bender.yml
package:
  name: ex_ft_stage

sources:
  - source/ex_alu_pkg.sv
  - source/ex_ft_pkg.sv
  - source/ex_pipe_stage.sv
  - source/ex_alu_core.sv
  - source/ex_majority_voter.sv
  - source/ex_fault_monitor.sv
  - source/ex_ft_stage.sv
  - target: test
    files:
      - testbench/ex_ft_checker.sv
      - testbench/ex_ft_scoreboard.sv
      - testbench/tb_ex_ft_stage.sv
